// ==== src/rv32_macros.svh ====
// RV32 memory/commit slice parameters
// Data memory size, bus latency and the NOP encoding

`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Data memory depth in 32-bit words
`define RV32_MEM_WORDS 256

// Cycles a request is presented, the done cycle included (at least 1)
`define RV32_MEM_LATENCY 3

// addi x0, x0, 0
`define RV32_NOP 32'h0000_0013

`endif

// ==== src/rv32_types.sv ====
// RV32 memory/commit slice shared types
// Data words, memory ops, CSR ids, pipeline buffers and the request
// records passed between the memory stage, CSR file and top level

package rv32_types;

    typedef logic [31:0] rv32_word;

    typedef enum logic [2:0] {
        MEM_NOP,
        MEM_LW,
        MEM_LBU,
        MEM_SW,
        MEM_SB
    } mem_op_t;

    // mtimecmp sits at a custom machine location
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MEPC     = 12'h341,
        CSR_MTIMECMP = 12'h7C0
    } csr_id_t;

    typedef struct packed {
        logic mpie;
        logic mie;
    } mstatus_t;

    typedef struct packed {
        mem_op_t    mem_op;
        logic       csr_wb;
        logic       is_mret;
        logic       is_bubble;
        logic       reg_wb;
        logic [4:0] rd;
    } ctrl_t;

    // result[0] is store data, result[1] is address or CSR value
    typedef struct packed {
        rv32_word       pc;
        rv32_word       instr;
        rv32_word [1:0] result;
        ctrl_t          ctrl;
    } exec_mem_buffer_t;

    typedef struct packed {
        rv32_word pc;
        rv32_word instr;
        rv32_word result;
        ctrl_t    ctrl;
    } mem_wb_buffer_t;

    typedef struct packed {
        rv32_word addr;
        mem_op_t  op;
        rv32_word data;
    } memory_request_t;

    typedef struct packed {
        csr_id_t  id;
        rv32_word value;
        logic     write;
    } csr_write_request_t;

    typedef struct packed {
        logic     do_interrupt;
        logic     is_mret;
        rv32_word from;
    } interrupt_request_t;

    // Empty slot with every action switched off
    function automatic ctrl_t create_bubble_ctrl();
        ctrl_t c;
        c           = '0;
        c.mem_op    = MEM_NOP;
        c.is_bubble = 1'b1;
        return c;
    endfunction

endpackage

// ==== src/rv32_mem_if.sv ====
// RV32 data bus
// Request held by the master until the memory raises done

`timescale 1ns/1ps

interface rv32_mem_if;

    rv32_types::rv32_word addr;
    rv32_types::mem_op_t  op;
    rv32_types::rv32_word wdata;
    rv32_types::rv32_word rdata;
    logic                 done;

    modport master (
        output addr, op, wdata,
        input  rdata, done
    );

    modport memory (
        input  addr, op, wdata,
        output rdata, done
    );

endinterface

// ==== src/rv32_mem_stage.sv ====
// RV32 memory stage
// Issues data bus requests, commits CSR writes, takes the timer interrupt
// and mret at the consolidation point and fills the writeback buffer

`timescale 1ns/1ps
`include "rv32_macros.svh"

module rv32_mem_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  rv32_types::rv32_word            mepc,
    input  rv32_types::mstatus_t            mstatus,
    input  logic                            mtip,
    input  rv32_types::exec_mem_buffer_t    exec_mem_buff,
    output rv32_types::mem_wb_buffer_t      mem_wb_buff,
    output logic                            stall,
    output rv32_types::interrupt_request_t  interrupt_request,
    rv32_mem_if.master                      mem,
    output rv32_types::csr_write_request_t  csr_write_request,
    output logic                            instr_retired
);

    rv32_types::memory_request_t req;
    rv32_types::mem_wb_buffer_t  next_buff;
    logic [7:0]                  load_byte;
    logic                        take_irq;
    logic                        flush;
    logic                        in_flight;

    always_comb begin
        csr_write_request.id    = rv32_types::csr_id_t'(exec_mem_buff.instr[31:20]);
        csr_write_request.value = exec_mem_buff.result[1];
        csr_write_request.write = exec_mem_buff.ctrl.csr_wb;

        req.addr = exec_mem_buff.result[1];
        req.op   = exec_mem_buff.ctrl.mem_op;
        req.data = exec_mem_buff.result[0];

        // A bus request already started is allowed to finish first
        take_irq = ~exec_mem_buff.ctrl.is_bubble & mtip & mstatus.mie & ~in_flight;

        interrupt_request.is_mret      = exec_mem_buff.ctrl.is_mret
                                         & ~exec_mem_buff.ctrl.is_bubble;
        interrupt_request.from         = interrupt_request.is_mret ? mepc : exec_mem_buff.pc;
        interrupt_request.do_interrupt = interrupt_request.is_mret | take_irq;

        // Consolidation point drops the side effects of a trapping slot
        if (interrupt_request.do_interrupt) begin
            req.op                  = rv32_types::MEM_NOP;
            csr_write_request.write = 1'b0;
        end

        stall = (req.op != rv32_types::MEM_NOP) & ~mem.done;
        flush = interrupt_request.do_interrupt & ~interrupt_request.is_mret;

        load_byte = mem.rdata[{req.addr[1:0], 3'b000} +: 8];

        next_buff.pc    = exec_mem_buff.pc;
        next_buff.instr = exec_mem_buff.instr;
        next_buff.ctrl  = exec_mem_buff.ctrl;
        case (req.op)
            rv32_types::MEM_LW:  next_buff.result = mem.rdata;
            rv32_types::MEM_LBU: next_buff.result = {24'b0, load_byte};
            default:             next_buff.result = exec_mem_buff.result[1];
        endcase

        instr_retired = ~exec_mem_buff.ctrl.is_bubble & ~stall & ~flush;
    end

    assign mem.addr  = req.addr;
    assign mem.op    = req.op;
    assign mem.wdata = req.data;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_wb_buff.pc     <= '0;
            mem_wb_buff.instr  <= `RV32_NOP;
            mem_wb_buff.result <= '0;
            mem_wb_buff.ctrl   <= rv32_types::create_bubble_ctrl();
        end else if (flush) begin
            mem_wb_buff.ctrl <= rv32_types::create_bubble_ctrl();
        end else if (stall) begin
            // Keep old data visible for bypass, mark slot empty
            mem_wb_buff.ctrl.is_bubble <= 1'b1;
        end else begin
            mem_wb_buff <= next_buff;
        end
    end

    // Request must be held until done
    a_op_stable_in_stall: assert property (@(posedge clk) disable iff (!resetn)
        stall |=> $stable(mem.op));

endmodule

// ==== src/rv32_csr_file.sv ====
// RV32 machine-mode CSR file
// mstatus, mtvec, mepc, retired-instruction counter and a machine timer
// with compare register; handles trap entry and mret

`timescale 1ns/1ps

module rv32_csr_file (
    input  logic                            clk,
    input  logic                            resetn,
    input  rv32_types::csr_write_request_t  csr_write_request,
    input  rv32_types::interrupt_request_t  interrupt_request,
    input  logic                            instr_retired,
    output rv32_types::rv32_word            mepc,
    output rv32_types::rv32_word            mtvec,
    output rv32_types::mstatus_t            mstatus,
    output logic                            mtip,
    output rv32_types::rv32_word            instret_count
);

    rv32_types::rv32_word mtime;
    rv32_types::rv32_word mtimecmp;
    logic                 trap_entry;
    logic                 trap_return;

    assign trap_entry  = interrupt_request.do_interrupt & ~interrupt_request.is_mret;
    assign trap_return = interrupt_request.do_interrupt & interrupt_request.is_mret;

    // Pending while the timer has reached the compare value
    assign mtip = (mtime >= mtimecmp);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mtime         <= '0;
            instret_count <= '0;
        end else begin
            mtime <= mtime + 32'd1;
            if (instr_retired) begin
                instret_count <= instret_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mtimecmp <= '1;
        end else if (trap_entry) begin
            mepc         <= interrupt_request.from;
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
        end else if (trap_return) begin
            mstatus.mie <= mstatus.mpie;
        end else if (csr_write_request.write) begin
            case (csr_write_request.id)
                rv32_types::CSR_MSTATUS: begin
                    mstatus.mie  <= csr_write_request.value[3];
                    mstatus.mpie <= csr_write_request.value[7];
                end
                rv32_types::CSR_MTVEC:    mtvec    <= csr_write_request.value;
                rv32_types::CSR_MEPC:     mepc     <= csr_write_request.value;
                rv32_types::CSR_MTIMECMP: mtimecmp <= csr_write_request.value;
                // Unknown locations ignore the write
                default: ;
            endcase
        end
    end

    // The stage suppresses CSR writes from a trapping slot
    a_no_write_on_trap: assert property (@(posedge clk) disable iff (!resetn)
        !(csr_write_request.write && interrupt_request.do_interrupt));

endmodule

// ==== src/rv32_data_mem.sv ====
// RV32 data memory
// Word-array RAM on the data bus, answering with done after a fixed
// number of request cycles; byte stores touch one lane only

`timescale 1ns/1ps
`include "rv32_macros.svh"

module rv32_data_mem (
    input  logic        clk,
    input  logic        resetn,
    rv32_mem_if.memory  mem
);

    localparam int IDX_W = $clog2(`RV32_MEM_WORDS);
    localparam int CNT_W = $clog2(`RV32_MEM_LATENCY + 1);

    rv32_types::rv32_word ram [`RV32_MEM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic [1:0]           lane;
    logic [CNT_W-1:0]     count;
    logic                 active;
    logic                 is_read;

    assign idx     = mem.addr[IDX_W+1:2];
    assign lane    = mem.addr[1:0];
    assign active  = (mem.op != rv32_types::MEM_NOP);
    assign is_read = (mem.op == rv32_types::MEM_LW) || (mem.op == rv32_types::MEM_LBU);

    // Done in the last of the latency cycles
    assign mem.done  = active && (count == CNT_W'(`RV32_MEM_LATENCY - 1));
    assign mem.rdata = (mem.done && is_read) ? ram[idx] : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (!active || mem.done) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.done) begin
            case (mem.op)
                rv32_types::MEM_SW: ram[idx] <= mem.wdata;
                rv32_types::MEM_SB: ram[idx][{lane, 3'b000} +: 8] <= mem.wdata[7:0];
                default: ;
            endcase
        end
    end

    // Counted request stays unchanged until done
    a_req_held: assert property (@(posedge clk) disable iff (!resetn)
        active && !mem.done |=> $stable(mem.op) && $stable(mem.addr) && $stable(mem.wdata));

endmodule

// ==== src/rv32_mem_subsys.sv ====
// RV32 memory/commit subsystem top
// Packs the execute-side ports into the stage buffer, wires the stage to
// the CSR file and data memory, and turns traps into a pc redirect

`timescale 1ns/1ps

module rv32_mem_subsys (
    input  logic                  clk,
    input  logic                  resetn,
    input  rv32_types::rv32_word  ex_pc,
    input  rv32_types::rv32_word  ex_instr,
    input  rv32_types::rv32_word  ex_store_data,
    input  rv32_types::rv32_word  ex_addr_value,
    input  rv32_types::mem_op_t   ex_mem_op,
    input  logic                  ex_csr_wb,
    input  logic                  ex_is_mret,
    input  logic                  ex_is_bubble,
    input  logic                  ex_reg_wb,
    input  logic [4:0]            ex_rd,
    output logic                  stall,
    output rv32_types::rv32_word  wb_pc,
    output rv32_types::rv32_word  wb_instr,
    output rv32_types::rv32_word  wb_result,
    output logic [4:0]            wb_rd,
    output logic                  wb_reg_wb,
    output logic                  wb_is_bubble,
    output logic                  redirect,
    output rv32_types::rv32_word  redirect_pc,
    output rv32_types::rv32_word  instret_count
);

    rv32_types::exec_mem_buffer_t   exec_buff;
    rv32_types::mem_wb_buffer_t     wb_buff;
    rv32_types::interrupt_request_t irq_req;
    rv32_types::csr_write_request_t csr_req;
    rv32_types::mstatus_t           mstatus;
    rv32_types::rv32_word           mepc;
    rv32_types::rv32_word           mtvec;
    logic                           mtip;
    logic                           instr_retired;

    rv32_mem_if data_bus ();

    always_comb begin
        exec_buff.pc             = ex_pc;
        exec_buff.instr          = ex_instr;
        exec_buff.result[0]      = ex_store_data;
        exec_buff.result[1]      = ex_addr_value;
        exec_buff.ctrl.mem_op    = ex_mem_op;
        exec_buff.ctrl.csr_wb    = ex_csr_wb;
        exec_buff.ctrl.is_mret   = ex_is_mret;
        exec_buff.ctrl.is_bubble = ex_is_bubble;
        exec_buff.ctrl.reg_wb    = ex_reg_wb;
        exec_buff.ctrl.rd        = ex_rd;
    end

    assign wb_pc        = wb_buff.pc;
    assign wb_instr     = wb_buff.instr;
    assign wb_result    = wb_buff.result;
    assign wb_rd        = wb_buff.ctrl.rd;
    assign wb_reg_wb    = wb_buff.ctrl.reg_wb;
    assign wb_is_bubble = wb_buff.ctrl.is_bubble;

    // mret returns to mepc, the timer interrupt enters at mtvec
    assign redirect    = irq_req.do_interrupt;
    assign redirect_pc = irq_req.is_mret ? mepc : mtvec;

    rv32_mem_stage u_mem_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mepc              (mepc),
        .mstatus           (mstatus),
        .mtip              (mtip),
        .exec_mem_buff     (exec_buff),
        .mem_wb_buff       (wb_buff),
        .stall             (stall),
        .interrupt_request (irq_req),
        .mem               (data_bus),
        .csr_write_request (csr_req),
        .instr_retired     (instr_retired)
    );

    rv32_csr_file u_csr_file (
        .clk               (clk),
        .resetn            (resetn),
        .csr_write_request (csr_req),
        .interrupt_request (irq_req),
        .instr_retired     (instr_retired),
        .mepc              (mepc),
        .mtvec             (mtvec),
        .mstatus           (mstatus),
        .mtip              (mtip),
        .instret_count     (instret_count)
    );

    rv32_data_mem u_data_mem (
        .clk    (clk),
        .resetn (resetn),
        .mem    (data_bus)
    );

endmodule

// ==== verif/rv32_mem_subsys_tb.sv ====
// RV32 memory/commit subsystem testbench
// Directed tests for loads and stores, pass-through, stall hold,
// the timer interrupt and mret

`timescale 1ns/1ps
`include "rv32_macros.svh"

module rv32_mem_subsys_tb;

    localparam int STALL_TIMEOUT = 50;

    logic                 clk;
    logic                 resetn;
    rv32_types::rv32_word ex_pc;
    rv32_types::rv32_word ex_instr;
    rv32_types::rv32_word ex_store_data;
    rv32_types::rv32_word ex_addr_value;
    rv32_types::mem_op_t  ex_mem_op;
    logic                 ex_csr_wb;
    logic                 ex_is_mret;
    logic                 ex_is_bubble;
    logic                 ex_reg_wb;
    logic [4:0]           ex_rd;
    logic                 stall;
    rv32_types::rv32_word wb_pc;
    rv32_types::rv32_word wb_instr;
    rv32_types::rv32_word wb_result;
    logic [4:0]           wb_rd;
    logic                 wb_reg_wb;
    logic                 wb_is_bubble;
    logic                 redirect;
    rv32_types::rv32_word redirect_pc;
    rv32_types::rv32_word instret_count;

    rv32_types::rv32_word lcg_state;
    int                   error_count;
    int                   checks_run;

    rv32_mem_subsys u_rv32_mem_subsys (.*);

    always #2 clk = ~clk;

    function automatic rv32_types::rv32_word lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Word-aligned address inside the data memory
    function automatic rv32_types::rv32_word rand_addr();
        return (lcg_next() >> 10) & rv32_types::rv32_word'((`RV32_MEM_WORDS - 1) * 4);
    endfunction

    task automatic check_word(input string name, input rv32_types::rv32_word exp,
                              input rv32_types::rv32_word act);
        checks_run++;
        if (act !== exp) begin
            error_count++;
            $display("ERR %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks_run++;
        if (act !== exp) begin
            error_count++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input rv32_types::rv32_word exp,
                               input rv32_types::rv32_word act);
        checks_run++;
        if (act !== exp) begin
            error_count++;
            $display("ERR %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic drive_instr(input rv32_types::rv32_word pc, input rv32_types::rv32_word instr,
                               input rv32_types::mem_op_t op,
                               input rv32_types::rv32_word store_data,
                               input rv32_types::rv32_word addr_value,
                               input logic csr_wb, input logic is_mret, input logic [4:0] rd);
        @(posedge clk);
        ex_pc         <= pc;
        ex_instr      <= instr;
        ex_mem_op     <= op;
        ex_store_data <= store_data;
        ex_addr_value <= addr_value;
        ex_csr_wb     <= csr_wb;
        ex_is_mret    <= is_mret;
        ex_is_bubble  <= 1'b0;
        ex_reg_wb     <= (rd != 5'd0);
        ex_rd         <= rd;
    endtask

    // Returns in the cycle where the slot completes, counting stalled cycles
    task automatic wait_stall(input string name, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (stall && cycles < STALL_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            error_count++;
            $display("%s: stall still high after %0d cycles", name, STALL_TIMEOUT);
        end
    endtask

    task automatic issue_instr(input string name, input rv32_types::rv32_word pc,
                               input rv32_types::rv32_word instr,
                               input rv32_types::mem_op_t op,
                               input rv32_types::rv32_word store_data,
                               input rv32_types::rv32_word addr_value,
                               input logic csr_wb, input logic is_mret,
                               input logic [4:0] rd, output int cycles);
        drive_instr(pc, instr, op, store_data, addr_value, csr_wb, is_mret, rd);
        wait_stall(name, cycles);
    endtask

    task automatic issue_mem(input string name, input rv32_types::rv32_word pc,
                             input rv32_types::mem_op_t op, input rv32_types::rv32_word addr,
                             input rv32_types::rv32_word data, output int cycles);
        rv32_types::rv32_word instr;
        instr = (op == rv32_types::MEM_LW || op == rv32_types::MEM_LBU) ? 32'h0000_2083
                                                                        : 32'h0000_2023;
        issue_instr(name, pc, instr, op, data, addr, 1'b0, 1'b0, 5'd1, cycles);
        check_count({name, " stall cycles"}, `RV32_MEM_LATENCY - 1, cycles);
    endtask

    // csrrw x0, id, x1
    task automatic write_csr(input rv32_types::rv32_word pc, input rv32_types::csr_id_t id,
                             input rv32_types::rv32_word value);
        int cycles;
        issue_instr("write_csr", pc, {id, 5'd1, 3'b001, 5'd0, 7'h73}, rv32_types::MEM_NOP,
                    '0, value, 1'b1, 1'b0, 5'd0, cycles);
    endtask

    task automatic send_bubble();
        @(posedge clk);
        ex_pc        <= '0;
        ex_instr     <= `RV32_NOP;
        ex_mem_op    <= rv32_types::MEM_NOP;
        ex_csr_wb    <= 1'b0;
        ex_is_mret   <= 1'b0;
        ex_is_bubble <= 1'b1;
        ex_reg_wb    <= 1'b0;
        ex_rd        <= 5'd0;
        @(negedge clk);
    endtask

    task automatic test_store_load();
        rv32_types::rv32_word addr;
        rv32_types::rv32_word data;
        int                   cycles;
        addr = rand_addr();
        data = lcg_next();
        issue_mem("store_load sw", 32'h100, rv32_types::MEM_SW, addr, data, cycles);
        issue_mem("store_load lw", 32'h104, rv32_types::MEM_LW, addr, '0, cycles);
        send_bubble();
        check_word("store_load lw result", data, wb_result);
        // Random byte lane within the same word
        addr = addr + (lcg_next() >> 30);
        data = lcg_next();
        issue_mem("store_load sb", 32'h108, rv32_types::MEM_SB, addr, data, cycles);
        issue_mem("store_load lbu", 32'h10C, rv32_types::MEM_LBU, addr, '0, cycles);
        send_bubble();
        check_word("store_load lbu result", {24'd0, data[7:0]}, wb_result);
    endtask

    task automatic test_pass_through();
        rv32_types::rv32_word base;
        rv32_types::rv32_word res;
        int                   cycles;
        send_bubble();
        base = instret_count;
        res  = lcg_next();
        issue_instr("pass_through", 32'h200, 32'h0070_0393, rv32_types::MEM_NOP, '0, res,
                    1'b0, 1'b0, 5'd7, cycles);
        send_bubble();
        check_word("pass_through wb_pc", 32'h200, wb_pc);
        check_word("pass_through wb_instr", 32'h0070_0393, wb_instr);
        check_word("pass_through wb_result", res, wb_result);
        check_word("pass_through wb_rd", 32'd7, {27'd0, wb_rd});
        check_bit("pass_through wb_reg_wb", 1'b1, wb_reg_wb);
        check_bit("pass_through wb_is_bubble", 1'b0, wb_is_bubble);
        issue_instr("pass_through", 32'h204, 32'h0010_0113, rv32_types::MEM_NOP, '0,
                    lcg_next(), 1'b0, 1'b0, 5'd2, cycles);
        issue_instr("pass_through", 32'h208, 32'h0020_0193, rv32_types::MEM_NOP, '0,
                    lcg_next(), 1'b0, 1'b0, 5'd3, cycles);
        send_bubble();
        send_bubble();
        check_count("pass_through instret", base + 32'd3, instret_count);
    endtask

    task automatic test_stall_hold();
        rv32_types::rv32_word addr;
        rv32_types::rv32_word data;
        rv32_types::rv32_word res;
        int                   cycles;
        addr = rand_addr();
        data = lcg_next();
        res  = lcg_next();
        issue_mem("stall_hold sw", 32'h300, rv32_types::MEM_SW, addr, data, cycles);
        issue_instr("stall_hold", 32'h304, 32'h0050_0293, rv32_types::MEM_NOP, '0, res,
                    1'b0, 1'b0, 5'd5, cycles);
        drive_instr(32'h308, 32'h0000_2083, rv32_types::MEM_LW, '0, addr, 1'b0, 1'b0, 5'd1);
        cycles = 0;
        @(negedge clk);
        while (stall && cycles < STALL_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            check_bit("stall_hold wb_is_bubble", 1'b1, wb_is_bubble);
            check_word("stall_hold wb_pc", 32'h304, wb_pc);
            check_word("stall_hold wb_result", res, wb_result);
        end
        if (stall) begin
            error_count++;
            $display("stall_hold: load never completed");
        end
        send_bubble();
        check_word("stall_hold lw result", data, wb_result);
        check_bit("stall_hold lw bubble", 1'b0, wb_is_bubble);
    endtask

    // Leaves mepc at 0x410 and mie clear for the mret test
    task automatic test_timer_irq();
        rv32_types::rv32_word addr;
        rv32_types::rv32_word old;
        int                   cycles;
        addr = rand_addr();
        old  = lcg_next();
        issue_mem("timer_irq sw", 32'h400, rv32_types::MEM_SW, addr, old, cycles);
        write_csr(32'h404, rv32_types::CSR_MTVEC, 32'h0000_0800);
        write_csr(32'h408, rv32_types::CSR_MSTATUS, 32'h0000_0008);
        write_csr(32'h40C, rv32_types::CSR_MTIMECMP, 32'h0);
        drive_instr(32'h410, 32'h0000_2023, rv32_types::MEM_SW, ~old, addr, 1'b0, 1'b0, 5'd0);
        @(negedge clk);
        check_bit("timer_irq redirect", 1'b1, redirect);
        check_word("timer_irq redirect_pc", 32'h0000_0800, redirect_pc);
        check_bit("timer_irq stall", 1'b0, stall);
        send_bubble();
        check_bit("timer_irq wb_is_bubble", 1'b1, wb_is_bubble);
        issue_mem("timer_irq lw", 32'h800, rv32_types::MEM_LW, addr, '0, cycles);
        send_bubble();
        check_word("timer_irq store suppressed", old, wb_result);
    endtask

    task automatic test_mret();
        write_csr(32'h804, rv32_types::CSR_MTIMECMP, 32'hFFFF_FFFF);
        drive_instr(32'h808, 32'h3020_0073, rv32_types::MEM_NOP, '0, '0, 1'b0, 1'b1, 5'd0);
        @(negedge clk);
        check_bit("mret redirect", 1'b1, redirect);
        check_word("mret redirect_pc", 32'h0000_0410, redirect_pc);
        write_csr(32'h410, rv32_types::CSR_MTIMECMP, 32'h0);
        check_word("mret wb_pc", 32'h808, wb_pc);
        check_bit("mret wb_is_bubble", 1'b0, wb_is_bubble);
        drive_instr(32'h414, 32'h0030_0193, rv32_types::MEM_NOP, '0, 32'h55, 1'b0, 1'b0, 5'd3);
        @(negedge clk);
        check_bit("mret second redirect", 1'b1, redirect);
        check_word("mret second redirect_pc", 32'h0000_0800, redirect_pc);
        send_bubble();
    endtask

    initial begin
        clk           = 1'b0;
        resetn        <= 1'b0;
        ex_pc         <= '0;
        ex_instr      <= `RV32_NOP;
        ex_store_data <= '0;
        ex_addr_value <= '0;
        ex_mem_op     <= rv32_types::MEM_NOP;
        ex_csr_wb     <= 1'b0;
        ex_is_mret    <= 1'b0;
        ex_is_bubble  <= 1'b1;
        ex_reg_wb     <= 1'b0;
        ex_rd         <= 5'd0;
        error_count   = 0;
        checks_run    = 0;
        lcg_state     = 32'd24;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_bit("reset stall", 1'b0, stall);
        check_bit("reset redirect", 1'b0, redirect);
        check_bit("reset wb_is_bubble", 1'b1, wb_is_bubble);
        check_word("reset wb_instr", `RV32_NOP, wb_instr);
        test_store_load();
        test_pass_through();
        test_stall_hold();
        test_timer_irq();
        test_mret();
        $display("Checks run: %0d, errors: %0d", checks_run, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== rv32_mem_subsys.f ====
+incdir+src
src/rv32_types.sv
src/rv32_mem_if.sv
src/rv32_mem_stage.sv
src/rv32_csr_file.sv
src/rv32_data_mem.sv
src/rv32_mem_subsys.sv
verif/rv32_mem_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := rv32_mem_subsys_tb
FILELIST  := rv32_mem_subsys.f
LOG       := sim.log

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
